/* hw/rt_defs.svh */
`ifndef RT_DEFS_SVH
`define RT_DEFS_SVH

// data path word, signed Q16.16
`define RT_WORD_W 32
`define RT_FRAC 16

////////////////////////////////////////////////////////////////////////////
// shading limits on the axis projection d
////////////////////////////////////////////////////////////////////////////
`define RT_PIN_HEIGHT 32'sh0078_0000   // 120.0
`define RT_RED_START 32'sh005A_0000    // 90.0
`define RT_RED_END 32'sh0060_0000      // 96.0

// hit point pipeline depth and result buffer size
`define RT_HP_LATENCY 4
`define RT_FIFO_DEPTH 8

`endif

/* hw/rt_geom_pkg.sv */
`include "rt_defs.svh"

package rt_geom_pkg;

  typedef logic signed [`RT_WORD_W-1:0] fx_t;   // Q16.16

  typedef struct packed {
    fx_t x;
    fx_t y;
    fx_t z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_t;

  typedef struct packed {
    vec3_t center;
    vec3_t axis;
    logic  is_cylinder;
  } obj_t;

  // one sample along the ray
  typedef struct packed {
    ray_t ray;
    obj_t obj;
    fx_t  t;
  } hit_req_t;

  typedef struct packed {
    vec3_t hit_pt;
    vec3_t normal;
    logic  invalid;   // cylinder hit outside the pin
    logic  red;       // d inside the red band
  } hit_rsp_t;

endpackage

/* hw/rt_ctrl_pkg.sv */
package rt_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } sweep_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // register map, word offsets (paddr[7:2])
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    ORIGIN_X = 6'h00, ORIGIN_Y = 6'h01, ORIGIN_Z = 6'h02,
    DIR_X    = 6'h03, DIR_Y    = 6'h04, DIR_Z    = 6'h05,
    CENTER_X = 6'h06, CENTER_Y = 6'h07, CENTER_Z = 6'h08,
    AXIS_X   = 6'h09, AXIS_Y   = 6'h0A, AXIS_Z   = 6'h0B,
    OBJ_CTRL = 6'h0C, T_START  = 6'h0D, T_STEP   = 6'h0E, COUNT = 6'h0F,
    CMD      = 6'h10, STATUS   = 6'h11,
    RES_HP_X = 6'h18, RES_HP_Y = 6'h19, RES_HP_Z = 6'h1A,
    RES_N_X  = 6'h1B, RES_N_Y  = 6'h1C, RES_N_Z  = 6'h1D,
    RES_FLAGS = 6'h1E
  } reg_addr_e;

endpackage

/* hw/hit_point.sv */
`timescale 1ns/1ps
`include "rt_defs.svh"

module hit_point
  import rt_geom_pkg::*;
(
  input  logic     aclk,
  input  logic     rst_n,
  input  hit_req_t req,
  input  logic     req_valid,
  output logic     req_ready,
  output hit_rsp_t rsp,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output logic     pipe_busy
);

  localparam int LAT = `RT_HP_LATENCY;

  ////////////////////////////////////////////////////////////////////////////
  // Q16.16 helpers, products keep bits [47:16] of the full product
  ////////////////////////////////////////////////////////////////////////////
  function automatic fx_t fx_mul(fx_t a, fx_t b);
    logic signed [2*`RT_WORD_W-1:0] p;
    p = a * b;
    return p[`RT_FRAC +: `RT_WORD_W];
  endfunction

  function automatic vec3_t vec_scale(vec3_t v, fx_t s);
    vec3_t r;
    r.x = fx_mul(v.x, s);
    r.y = fx_mul(v.y, s);
    r.z = fx_mul(v.z, s);
    return r;
  endfunction

  function automatic vec3_t vec_add(vec3_t a, vec3_t b);
    vec3_t r;
    r.x = a.x + b.x;
    r.y = a.y + b.y;
    r.z = a.z + b.z;
    return r;
  endfunction

  function automatic vec3_t vec_sub(vec3_t a, vec3_t b);
    vec3_t r;
    r.x = a.x - b.x;
    r.y = a.y - b.y;
    r.z = a.z - b.z;
    return r;
  endfunction

  function automatic fx_t vec_dot(vec3_t a, vec3_t b);
    return fx_mul(a.x, b.x) + fx_mul(a.y, b.y) + fx_mul(a.z, b.z);
  endfunction

  logic [LAT-1:0] vld;
  logic           adv;

  vec3_t s1_org, s1_dt, s1_ctr, s1_axis;
  logic  s1_cyl;
  vec3_t s2_hp, s2_pn, s2_axis;
  logic  s2_cyl;
  vec3_t s3_hp, s3_pn, s3_axis;
  fx_t   s3_d;
  logic  s3_cyl;

  assign adv       = ~vld[LAT-1] | rsp_ready;   // whole pipe moves together
  assign req_ready = adv;
  assign rsp_valid = vld[LAT-1];
  assign pipe_busy = |vld;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (adv) begin
      vld <= {vld[LAT-2:0], req_valid};
    end
  end

  always_ff @(posedge aclk) begin
    if (adv) begin
      // stage 1: dir * t
      s1_org  <= req.ray.origin;
      s1_dt   <= vec_scale(req.ray.dir, req.t);
      s1_ctr  <= req.obj.center;
      s1_axis <= req.obj.axis;
      s1_cyl  <= req.obj.is_cylinder;
      // stage 2: hit point and pre-normal
      s2_hp   <= vec_add(s1_org, s1_dt);
      s2_pn   <= vec_sub(vec_add(s1_org, s1_dt), s1_ctr);
      s2_axis <= s1_axis;
      s2_cyl  <= s1_cyl;
      // stage 3: projection on the axis
      s3_hp   <= s2_hp;
      s3_pn   <= s2_pn;
      s3_axis <= s2_axis;
      s3_d    <= vec_dot(s2_pn, s2_axis);
      s3_cyl  <= s2_cyl;
      // stage 4: normal and flags
      rsp.hit_pt  <= s3_hp;
      rsp.normal  <= vec_sub(s3_pn, vec_scale(s3_axis, s3_d));
      rsp.invalid <= s3_cyl & ((s3_d < 0) | (s3_d > `RT_PIN_HEIGHT));
      rsp.red     <= (s3_d > `RT_RED_START) & (s3_d < `RT_RED_END);
    end
  end

  a_rsp_hold : assert property (@(posedge aclk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> $stable(rsp));

endmodule

/* hw/t_stepper.sv */
`timescale 1ns/1ps

module t_stepper
  import rt_geom_pkg::*;
(
  input  logic        aclk,
  input  logic        rst_n,
  input  logic        load,
  input  logic        step,
  input  fx_t         t_start,
  input  fx_t         t_step,
  input  logic [15:0] count,
  output fx_t         t,
  output logic        last,
  output logic        empty
);

  logic [15:0] remain;   // samples not yet issued

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      t      <= '0;
      remain <= '0;
    end else if (load) begin
      t      <= t_start;
      remain <= count;
    end else if (step) begin
      t      <= t + t_step;   // wraps at 32 bits
      remain <= remain - 16'd1;
    end
  end

  assign last  = (remain == 16'd1);
  assign empty = (remain == 16'd0);

endmodule

/* hw/sweep_fsm.sv */
`timescale 1ns/1ps

module sweep_fsm
  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;
(
  input  logic     aclk,
  input  logic     rst_n,
  input  logic     start,
  input  ray_t     ray,
  input  obj_t     obj,
  input  fx_t      t,
  input  logic     last,
  input  logic     empty,
  output logic     load,
  output logic     step,
  output hit_req_t req,
  output logic     req_valid,
  input  logic     req_ready,
  input  logic     pipe_busy,
  output logic     busy,
  output logic     done
);

  sweep_state_e state;
  logic         issue;

  assign load      = (state == IDLE) & start;   // start elsewhere is dropped
  assign req_valid = (state == RUN) & ~empty;
  assign issue     = req_valid & req_ready;
  assign step      = issue;
  assign busy      = (state != IDLE);
  assign req       = '{ray: ray, obj: obj, t: t};

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            done  <= 1'b0;
          end
        end
        RUN: begin
          if (empty || (issue && last)) state <= DRAIN;   // count 0 issues nothing
        end
        DRAIN: begin
          if (!pipe_busy) begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_req_in_run : assert property (@(posedge aclk) disable iff (!rst_n)
    req_valid |-> state == RUN);

endmodule

/* hw/result_fifo.sv */
`timescale 1ns/1ps
`include "rt_defs.svh"

module result_fifo
  import rt_geom_pkg::*;
#(
  parameter int DEPTH = `RT_FIFO_DEPTH
) (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  hit_rsp_t               wr_data,
  input  logic                   wr_valid,
  output logic                   wr_ready,
  output hit_rsp_t               rd_data,
  output logic                   rd_valid,
  input  logic                   pop,
  output logic [$clog2(DEPTH):0] level
);

  localparam int AW = $clog2(DEPTH);

  hit_rsp_t      mem [DEPTH];
  logic [AW:0]   wr_ptr;   // extra bit tells full from empty
  logic [AW:0]   rd_ptr;

  assign level    = wr_ptr - rd_ptr;
  assign wr_ready = (level != DEPTH[AW:0]);
  assign rd_valid = (level != '0);
  assign rd_data  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge aclk) begin
    if (wr_valid && wr_ready) mem[wr_ptr[AW-1:0]] <= wr_data;
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_valid && wr_ready) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  a_no_underflow : assert property (@(posedge aclk) disable iff (!rst_n)
    pop |-> rd_valid);

endmodule

/* hw/apb_regs.sv */
`timescale 1ns/1ps
`include "rt_defs.svh"

module apb_regs
  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [`RT_WORD_W-1:0] pwdata,
  output logic [`RT_WORD_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output ray_t                  cfg_ray,
  output obj_t                  cfg_obj,
  output fx_t                   t_start,
  output fx_t                   t_step,
  output logic [15:0]           count,
  output logic                  start,
  input  logic                  busy,
  input  logic                  done,
  input  hit_rsp_t              res,
  input  logic                  res_valid,
  input  logic [3:0]            level,
  output logic                  pop
);

  reg_addr_e addr;
  hit_rsp_t  head;   // zero while the FIFO is empty
  logic      access;
  logic      mapped;
  logic      ro;
  logic      wr_en;

  assign addr    = reg_addr_e'(paddr[7:2]);
  assign head    = res_valid ? res : '0;
  assign access  = psel & penable;
  assign pready  = 1'b1;
  assign wr_en   = access & pwrite & mapped & ~ro;
  assign pslverr = access & (~mapped | (pwrite & ro));
  assign start   = wr_en & (addr == CMD) & pwdata[0];
  assign pop     = access & ~pwrite & (addr == RES_FLAGS) & res_valid;

  ////////////////////////////////////////////////////////////////////////////
  // read mux and decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    prdata = '0;
    mapped = 1'b1;
    ro     = 1'b0;
    case (addr)
      ORIGIN_X:  prdata = cfg_ray.origin.x;
      ORIGIN_Y:  prdata = cfg_ray.origin.y;
      ORIGIN_Z:  prdata = cfg_ray.origin.z;
      DIR_X:     prdata = cfg_ray.dir.x;
      DIR_Y:     prdata = cfg_ray.dir.y;
      DIR_Z:     prdata = cfg_ray.dir.z;
      CENTER_X:  prdata = cfg_obj.center.x;
      CENTER_Y:  prdata = cfg_obj.center.y;
      CENTER_Z:  prdata = cfg_obj.center.z;
      AXIS_X:    prdata = cfg_obj.axis.x;
      AXIS_Y:    prdata = cfg_obj.axis.y;
      AXIS_Z:    prdata = cfg_obj.axis.z;
      OBJ_CTRL:  prdata = {31'b0, cfg_obj.is_cylinder};
      T_START:   prdata = t_start;
      T_STEP:    prdata = t_step;
      COUNT:     prdata = {16'b0, count};
      CMD:       prdata = '0;   // write only, reads as zero
      STATUS: begin
        prdata = {20'b0, level, 6'b0, done, busy};
        ro     = 1'b1;
      end
      RES_HP_X:  begin prdata = head.hit_pt.x; ro = 1'b1; end
      RES_HP_Y:  begin prdata = head.hit_pt.y; ro = 1'b1; end
      RES_HP_Z:  begin prdata = head.hit_pt.z; ro = 1'b1; end
      RES_N_X:   begin prdata = head.normal.x; ro = 1'b1; end
      RES_N_Y:   begin prdata = head.normal.y; ro = 1'b1; end
      RES_N_Z:   begin prdata = head.normal.z; ro = 1'b1; end
      RES_FLAGS: begin prdata = {30'b0, head.red, head.invalid}; ro = 1'b1; end
      default:   mapped = 1'b0;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ray <= '0;
      cfg_obj <= '0;
      t_start <= '0;
      t_step  <= '0;
      count   <= '0;
    end else if (wr_en) begin
      case (addr)
        ORIGIN_X: cfg_ray.origin.x    <= pwdata;
        ORIGIN_Y: cfg_ray.origin.y    <= pwdata;
        ORIGIN_Z: cfg_ray.origin.z    <= pwdata;
        DIR_X:    cfg_ray.dir.x       <= pwdata;
        DIR_Y:    cfg_ray.dir.y       <= pwdata;
        DIR_Z:    cfg_ray.dir.z       <= pwdata;
        CENTER_X: cfg_obj.center.x    <= pwdata;
        CENTER_Y: cfg_obj.center.y    <= pwdata;
        CENTER_Z: cfg_obj.center.z    <= pwdata;
        AXIS_X:   cfg_obj.axis.x      <= pwdata;
        AXIS_Y:   cfg_obj.axis.y      <= pwdata;
        AXIS_Z:   cfg_obj.axis.z      <= pwdata;
        OBJ_CTRL: cfg_obj.is_cylinder <= pwdata[0];
        T_START:  t_start             <= pwdata;
        T_STEP:   t_step              <= pwdata;
        COUNT:    count               <= pwdata[15:0];
        default:  ;
      endcase
    end
  end

endmodule

/* hw/hit_engine_top.sv */
`timescale 1ns/1ps
`include "rt_defs.svh"

module hit_engine_top
  import rt_geom_pkg::*;
(
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [7:0]            paddr,
  input  logic [`RT_WORD_W-1:0] pwdata,
  output logic [`RT_WORD_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr
);

  ray_t        cfg_ray;
  obj_t        cfg_obj;
  fx_t         t_start, t_step, t;
  logic [15:0] count;
  logic        start, load, step, last, empty;
  logic        busy, done, pipe_busy;
  hit_req_t    req;
  logic        req_valid, req_ready;
  hit_rsp_t    rsp, res;
  logic        rsp_valid, rsp_ready;
  logic        res_valid, pop;
  logic [$clog2(`RT_FIFO_DEPTH):0] level;

  apb_regs u_regs (
    .aclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .cfg_ray, .cfg_obj, .t_start, .t_step, .count, .start,
    .busy, .done, .res, .res_valid, .level, .pop
  );

  sweep_fsm u_fsm (
    .aclk, .rst_n, .start, .ray(cfg_ray), .obj(cfg_obj), .t, .last, .empty,
    .load, .step, .req, .req_valid, .req_ready, .pipe_busy, .busy, .done
  );

  t_stepper u_stepper (
    .aclk, .rst_n, .load, .step, .t_start, .t_step, .count, .t, .last, .empty
  );

  hit_point u_hit (
    .aclk, .rst_n, .req, .req_valid, .req_ready,
    .rsp, .rsp_valid, .rsp_ready, .pipe_busy
  );

  // full FIFO stalls the whole pipeline
  result_fifo #(.DEPTH(`RT_FIFO_DEPTH)) u_fifo (
    .aclk, .rst_n, .wr_data(rsp), .wr_valid(rsp_valid), .wr_ready(rsp_ready),
    .rd_data(res), .rd_valid(res_valid), .pop, .level
  );

endmodule

/* verif/hit_engine_tb.sv */
`timescale 1ns/1ps
`include "rt_defs.svh"

module hit_engine_tb
  import rt_geom_pkg::*;
  import rt_ctrl_pkg::*;
();

  localparam int DRV       = 1;                       // input drive delay after the edge
  localparam int DEPTH     = `RT_FIFO_DEPTH;
  localparam int ONE       = 1 << `RT_FRAC;           // 1.0 in Q16.16
  localparam int PIN_H     = 120 * ONE;
  localparam int RED_LO    = 90 * ONE;
  localparam int RED_HI    = 96 * ONE;
  localparam int SWEEP_SUM = 5 + 4 + 12 + 3 + 0;      // samples over all sweeps
  localparam int WD_CYCLES = SWEEP_SUM * 20 + 2000;
  localparam int POLL_MAX  = 200;

  logic        aclk;
  logic        rst_n;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  logic        chk_rd;     // expected APB response for the assertions
  logic [31:0] exp_rd;
  logic        exp_err;
  string       rd_name;
  logic        bp_phase;   // results held back on purpose

  int          seed;
  int          errors;
  int          checks;
  int          err_mark;
  int          cfg_w [16];   // config registers by word offset
  hit_rsp_t    exp_q [$];

  hit_engine_top UUT (
    .aclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge aclk);
    $display("watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////////////////////
  a_prdata : assert property (@(posedge aclk) disable iff (!rst_n)
    psel && penable && !pwrite && chk_rd |-> prdata == exp_rd)
    else begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, rd_name,
               $sampled(prdata), $sampled(exp_rd));
    end

  a_pslverr : assert property (@(posedge aclk) disable iff (!rst_n)
    psel && penable |-> pslverr == exp_err)
    else begin
      errors++;
      $display("ERROR %0t: pslverr got %b expected %b", $time,
               $sampled(pslverr), $sampled(exp_err));
    end

  a_pready : assert property (@(posedge aclk) disable iff (!rst_n)
    psel && penable |-> pready)
    else begin
      errors++;
      $display("ERROR %0t: pready got 0 expected 1", $time);
    end

  a_busy_full : assert property (@(posedge aclk) disable iff (!rst_n)
    bp_phase && UUT.level == DEPTH |-> UUT.busy)
    else begin
      errors++;
      $display("ERROR %0t: busy got 0 expected 1", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic int q_mul(int a, int b);
    longint p;
    p = longint'(a) * longint'(b);
    return int'(p >>> `RT_FRAC);
  endfunction

  function automatic hit_rsp_t model_hit(int t);
    hit_rsp_t r;
    int       hp [3];
    int       pn [3];
    int       d;
    d = 0;
    for (int i = 0; i < 3; i++) begin
      hp[i] = cfg_w[ORIGIN_X + i] + q_mul(cfg_w[DIR_X + i], t);
      pn[i] = hp[i] - cfg_w[CENTER_X + i];
      d     = d + q_mul(pn[i], cfg_w[AXIS_X + i]);
    end
    r.hit_pt.x = hp[0];
    r.hit_pt.y = hp[1];
    r.hit_pt.z = hp[2];
    r.normal.x = pn[0] - q_mul(cfg_w[AXIS_X], d);
    r.normal.y = pn[1] - q_mul(cfg_w[AXIS_Y], d);
    r.normal.z = pn[2] - q_mul(cfg_w[AXIS_Z], d);
    r.invalid  = cfg_w[OBJ_CTRL][0] && (d < 0 || d > PIN_H);
    r.red      = (d > RED_LO) && (d < RED_HI);
    return r;
  endfunction

  function automatic int small_rand(int mag);
    int r;
    r = $random(seed);
    return r % (mag * ONE);   // keeps the sign of r
  endfunction

  task automatic queue_sweep();
    for (int k = 0; k < cfg_w[COUNT]; k++) begin
      exp_q.push_back(model_hit(cfg_w[T_START] + k * cfg_w[T_STEP]));
    end
  endtask

  task automatic random_config(input int cyl, input int cnt);
    for (int i = 0; i < 12; i++) begin
      cfg_w[i] = small_rand(8);
    end
    cfg_w[OBJ_CTRL] = cyl;
    cfg_w[T_START]  = small_rand(4);
    cfg_w[T_STEP]   = small_rand(1);
    cfg_w[COUNT]    = cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////////////////////
  task automatic tick();
    @(posedge aclk);
    #DRV;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    exp_err = err;
    tick();
    penable = 1'b1;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    exp_err = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, input logic [31:0] expv, input logic chk,
                          input logic err, input string name, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    chk_rd  = chk;
    exp_rd  = expv;
    exp_err = err;
    rd_name = name;
    tick();
    penable = 1'b1;
    data    = prdata;   // decoded from paddr and settled since setup
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    chk_rd  = 1'b0;
    exp_err = 1'b0;
    if (chk) checks++;
  endtask

  task automatic read_check(input reg_addr_e r, input logic [31:0] expv);
    logic [31:0] d;
    apb_read({r, 2'b00}, expv, 1'b1, 1'b0, r.name(), d);
  endtask

  task automatic read_status(output logic [31:0] s);
    apb_read({STATUS, 2'b00}, 32'h0, 1'b0, 1'b0, "STATUS", s);
  endtask

  task automatic load_config();
    for (int i = 0; i < 16; i++) begin
      apb_write(8'(i * 4), cfg_w[i], 1'b0);
    end
  endtask

  task automatic start_sweep();
    apb_write({CMD, 2'b00}, 32'h1, 1'b0);
  endtask

  task automatic wait_done();
    logic [31:0] s;
    int          polls;
    s     = '0;
    polls = 0;
    while (!s[1] && polls < POLL_MAX) begin
      read_status(s);
      polls++;
    end
    if (!s[1]) begin
      errors++;
      $display("sweep did not report done within %0d status polls", POLL_MAX);
    end
  endtask

  task automatic wait_level(input int lvl);
    logic [31:0] s;
    int          polls;
    s     = '0;
    polls = 0;
    while (s[11:8] != lvl && polls < POLL_MAX) begin
      read_status(s);
      polls++;
    end
    if (s[11:8] != lvl) begin
      errors++;
      $display("result FIFO level never reached %0d", lvl);
    end
  endtask

  task automatic check_result();
    hit_rsp_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("a result was read that the model does not expect");
    end else begin
      e = exp_q.pop_front();
      read_check(RES_HP_X, e.hit_pt.x);
      read_check(RES_HP_Y, e.hit_pt.y);
      read_check(RES_HP_Z, e.hit_pt.z);
      read_check(RES_N_X, e.normal.x);
      read_check(RES_N_Y, e.normal.y);
      read_check(RES_N_Z, e.normal.z);
      read_check(RES_FLAGS, {30'b0, e.red, e.invalid});   // pops the head
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rdata;
    seed     = 32'haa0e_e910;
    errors   = 0;
    checks   = 0;
    err_mark = 0;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    chk_rd   = 1'b0;
    exp_rd   = '0;
    exp_err  = 1'b0;
    rd_name  = "";
    bp_phase = 1'b0;
    repeat (8) @(posedge aclk);
    #DRV;
    rst_n = 1'b1;

    read_check(STATUS, 32'h0);
    for (int i = 0; i < 16; i++) begin
      cfg_w[i] = $random(seed);
    end
    cfg_w[OBJ_CTRL] = 1;
    cfg_w[COUNT]    = cfg_w[COUNT] & 32'hFFFF;
    load_config();
    for (int i = 0; i < 16; i++) begin
      read_check(reg_addr_e'(i), cfg_w[i]);
    end
    read_check(CMD, 32'h0);
    apb_read(8'h50, 32'h0, 1'b1, 1'b1, "unmapped", rdata);   // hole in the map
    apb_write({STATUS, 2'b00}, 32'h0, 1'b1);                 // read-only register
    report_test(1, "reset and registers");

    random_config(0, 5);
    load_config();
    queue_sweep();
    start_sweep();
    wait_done();
    read_check(STATUS, 32'h502);
    repeat (5) check_result();
    read_check(STATUS, 32'h2);
    report_test(2, "sphere sweep");

    // d equals t here and the samples sit at -14.0, 39.5, 93.0 and 146.5
    cfg_w = '{ONE, -2 * ONE, 3 * ONE, ONE / 2, 0, ONE, ONE, -2 * ONE, 3 * ONE,
              0, 0, ONE, 1, -14 * ONE, 107 * ONE / 2, 4};
    load_config();
    queue_sweep();
    start_sweep();
    wait_done();
    read_check(STATUS, 32'h402);
    repeat (4) check_result();
    report_test(3, "cylinder flags");

    random_config(0, 12);
    load_config();
    queue_sweep();
    start_sweep();
    bp_phase = 1'b1;
    wait_level(DEPTH);
    read_check(STATUS, (DEPTH << 8) | 1);   // full and still busy
    bp_phase = 1'b0;
    repeat (12) check_result();
    wait_done();
    read_check(STATUS, 32'h2);
    report_test(4, "back-pressure");

    random_config(1, 3);
    load_config();
    queue_sweep();
    start_sweep();
    start_sweep();   // lands while the first sweep runs
    wait_done();
    read_check(STATUS, 32'h302);
    repeat (3) check_result();
    read_check(STATUS, 32'h2);
    apb_write({COUNT, 2'b00}, 32'h0, 1'b0);
    start_sweep();
    wait_done();
    read_check(STATUS, 32'h2);
    read_check(RES_FLAGS, 32'h0);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    report_test(5, "start handling");

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/rt_geom_pkg.sv
hw/rt_ctrl_pkg.sv
hw/hit_point.sv
hw/t_stepper.sv
hw/sweep_fsm.sv
hw/result_fifo.sv
hw/apb_regs.sv
hw/hit_engine_top.sv
verif/hit_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the hit engine testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module hit_engine_tb \
  -f vlog.f -o hit_engine_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/hit_engine_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
# the log decides the result
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation did not finish cleanly"; exit 1; }
echo "simulation passed"
exit 0
